/* design/rv32i_isa_pkg.sv */
package rv32i_isa_pkg;

    // Major opcodes
    parameter logic [6:0] OPC_LUI   = 7'b0110111;
    parameter logic [6:0] OPC_AUIPC = 7'b0010111;
    parameter logic [6:0] OPC_JAL   = 7'b1101111;
    parameter logic [6:0] OPC_JALR  = 7'b1100111;
    parameter logic [6:0] OPC_B     = 7'b1100011;  // Conditional branches
    parameter logic [6:0] OPC_IL    = 7'b0000011;  // Loads
    parameter logic [6:0] OPC_S     = 7'b0100011;  // Stores
    parameter logic [6:0] OPC_I     = 7'b0010011;  // ALU with immediate
    parameter logic [6:0] OPC_R     = 7'b0110011;  // ALU register-register
    parameter logic [6:0] OPC_FENCE = 7'b0001111;
    parameter logic [6:0] OPC_E     = 7'b1110011;  // ECALL, EBREAK

    // Branch funct3
    parameter logic [2:0] F3_BEQ  = 3'b000;
    parameter logic [2:0] F3_BNE  = 3'b001;
    parameter logic [2:0] F3_BLT  = 3'b100;
    parameter logic [2:0] F3_BGE  = 3'b101;
    parameter logic [2:0] F3_BLTU = 3'b110;
    parameter logic [2:0] F3_BGEU = 3'b111;

    // Load and store funct3
    parameter logic [2:0] F3_LB  = 3'b000;
    parameter logic [2:0] F3_LH  = 3'b001;
    parameter logic [2:0] F3_LW  = 3'b010;
    parameter logic [2:0] F3_LBU = 3'b100;
    parameter logic [2:0] F3_LHU = 3'b101;
    parameter logic [2:0] F3_SB  = 3'b000;
    parameter logic [2:0] F3_SH  = 3'b001;
    parameter logic [2:0] F3_SW  = 3'b010;

    // ALU funct3, shared by R and I forms
    parameter logic [2:0] F3_ADD  = 3'b000;  // ADD, SUB, ADDI
    parameter logic [2:0] F3_SLL  = 3'b001;
    parameter logic [2:0] F3_SLT  = 3'b010;
    parameter logic [2:0] F3_SLTU = 3'b011;
    parameter logic [2:0] F3_XOR  = 3'b100;
    parameter logic [2:0] F3_SR   = 3'b101;  // SRL, SRA and immediates
    parameter logic [2:0] F3_OR   = 3'b110;
    parameter logic [2:0] F3_AND  = 3'b111;

    parameter logic [2:0] F3_JALR  = 3'b000;
    parameter logic [2:0] F3_FENCE = 3'b000;

    parameter logic [6:0] F7_BASE = 7'b0000000;
    parameter logic [6:0] F7_ALT  = 7'b0100000;  // SUB, SRA, SRAI

    parameter logic [31:0] NOP_WORD = 32'h0000_0013;  // addi x0, x0, 0

    // Same word seen as I-type or as S/B-type
    typedef union packed {
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_view;
        struct packed {
            logic [6:0] imm_hi;  // Also funct7 for R and shifts
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_view;
    } rv32i_word_u;

endpackage

/* design/pipe_trk_pkg.sv */
package pipe_trk_pkg;

    parameter int XLEN     = 32;
    parameter int N_STAGES = 6;

    // Stage positions, fetch side first
    parameter int STG_IF  = 0;
    parameter int STG_PD  = 1;
    parameter int STG_ID  = 2;
    parameter int STG_EX  = 3;
    parameter int STG_MEM = 4;
    parameter int STG_WB  = 5;

endpackage

/* design/rv32i_decoder.sv */
`timescale 1ns/1ps

module rv32i_decoder (
    input  rv32i_isa_pkg::rv32i_word_u        inst_i,
    output logic                              illegal_o,
    output logic                              is_xori_o,
    output logic [4:0]                        rs1_o,
    output logic [pipe_trk_pkg::XLEN-1:0]     imm_i_o
);

    logic [6:0]                    opcode;
    logic [2:0]                    funct3;
    logic [6:0]                    funct7;
    logic [4:0]                    rd;
    logic [11:0]                   imm12;
    logic [pipe_trk_pkg::XLEN-1:0] imm_b;
    logic [pipe_trk_pkg::XLEN-1:0] imm_j;
    logic                          legal;

    assign opcode = inst_i.i_view.opcode;
    assign funct3 = inst_i.i_view.funct3;
    assign rd     = inst_i.i_view.rd;
    assign imm12  = inst_i.i_view.imm12;
    assign funct7 = inst_i.s_view.imm_hi;
    assign rs1_o  = inst_i.i_view.rs1;

    assign imm_i_o = {{20{imm12[11]}}, imm12};
    assign imm_b = {{19{inst_i.s_view.imm_hi[6]}}, inst_i.s_view.imm_hi[6],
                    inst_i.s_view.imm_lo[0], inst_i.s_view.imm_hi[5:0],
                    inst_i.s_view.imm_lo[4:1], 1'b0};
    // rs1 and funct3 carry imm[19:12] in J format
    assign imm_j = {{11{imm12[11]}}, imm12[11], inst_i.i_view.rs1, funct3,
                    imm12[0], imm12[10:1], 1'b0};

    always_comb begin
        case (opcode)
            rv32i_isa_pkg::OPC_LUI, rv32i_isa_pkg::OPC_AUIPC: legal = 1'b1;
            rv32i_isa_pkg::OPC_JAL: legal = (imm_j[1:0] == 2'b00);
            rv32i_isa_pkg::OPC_JALR:
                legal = (funct3 == rv32i_isa_pkg::F3_JALR) && (imm_i_o[1:0] == 2'b00);
            rv32i_isa_pkg::OPC_B:
                legal = (funct3 inside {rv32i_isa_pkg::F3_BEQ, rv32i_isa_pkg::F3_BNE,
                                        rv32i_isa_pkg::F3_BLT, rv32i_isa_pkg::F3_BGE,
                                        rv32i_isa_pkg::F3_BLTU, rv32i_isa_pkg::F3_BGEU})
                        && (imm_b[1:0] == 2'b00);
            rv32i_isa_pkg::OPC_IL:
                legal = funct3 inside {rv32i_isa_pkg::F3_LB, rv32i_isa_pkg::F3_LH,
                                       rv32i_isa_pkg::F3_LW, rv32i_isa_pkg::F3_LBU,
                                       rv32i_isa_pkg::F3_LHU};
            rv32i_isa_pkg::OPC_S:
                legal = funct3 inside {rv32i_isa_pkg::F3_SB, rv32i_isa_pkg::F3_SH,
                                       rv32i_isa_pkg::F3_SW};
            rv32i_isa_pkg::OPC_I: begin
                // Only the shifts constrain the upper immediate bits
                if (funct3 == rv32i_isa_pkg::F3_SLL)
                    legal = (funct7 == rv32i_isa_pkg::F7_BASE);
                else if (funct3 == rv32i_isa_pkg::F3_SR)
                    legal = funct7 inside {rv32i_isa_pkg::F7_BASE, rv32i_isa_pkg::F7_ALT};
                else
                    legal = 1'b1;
            end
            rv32i_isa_pkg::OPC_R:
                legal = (funct7 == rv32i_isa_pkg::F7_BASE) ||
                        ((funct7 == rv32i_isa_pkg::F7_ALT) &&
                         (funct3 inside {rv32i_isa_pkg::F3_ADD, rv32i_isa_pkg::F3_SR}));
            rv32i_isa_pkg::OPC_FENCE: legal = (funct3 == rv32i_isa_pkg::F3_FENCE);
            rv32i_isa_pkg::OPC_E:  // ECALL or EBREAK, all other fields zero
                legal = (imm12 inside {12'h000, 12'h001}) && (rs1_o == 5'd0) &&
                        (funct3 == 3'b000) && (rd == 5'd0);
            default: legal = 1'b0;
        endcase
    end

    assign illegal_o = !legal;
    assign is_xori_o = (opcode == rv32i_isa_pkg::OPC_I) && (funct3 == rv32i_isa_pkg::F3_XOR);

endmodule

/* design/pipe_stage_reg.sv */
`timescale 1ns/1ps

module pipe_stage_reg #(
    parameter logic [pipe_trk_pkg::XLEN-1:0] PC_RESET = '0
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          hold_i,
    input  logic                          flush_i,
    input  logic                          bubble_in_i,
    input  logic [pipe_trk_pkg::XLEN-1:0] inst_i,
    input  logic [pipe_trk_pkg::XLEN-1:0] pc_i,
    output logic [pipe_trk_pkg::XLEN-1:0] inst_o,
    output logic [pipe_trk_pkg::XLEN-1:0] pc_o,
    output logic                          bubble_o
);

    logic [pipe_trk_pkg::XLEN-1:0] inst_q;
    logic [pipe_trk_pkg::XLEN-1:0] pc_q;
    logic                          bubble_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            inst_q   <= rv32i_isa_pkg::NOP_WORD;
            pc_q     <= PC_RESET;
            bubble_q <= 1'b1;
        end else if (flush_i) begin
            bubble_q <= 1'b1;  // Word stays, marked dead
        end else if (!hold_i) begin
            inst_q   <= inst_i;
            pc_q     <= pc_i;
            bubble_q <= bubble_in_i;
        end
    end

    assign inst_o   = inst_q;
    assign pc_o     = pc_q;
    assign bubble_o = bubble_q;

endmodule

/* design/pipe_follower.sv */
`timescale 1ns/1ps

module pipe_follower #(
    parameter logic [pipe_trk_pkg::XLEN-1:0] PC_RESET = '0
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [pipe_trk_pkg::XLEN-1:0] fetch_inst_i,
    input  logic [pipe_trk_pkg::XLEN-1:0] fetch_pc_i,
    input  logic                          fetch_valid_i,
    input  logic                          pd_flush_i,
    input  logic                          bu_flush_i,
    input  logic                          pd_stall_i,
    input  logic                          id_stall_i,
    input  logic                          ex_stall_i,
    input  logic                          wb_stall_i,
    output logic [pipe_trk_pkg::XLEN-1:0] wb_inst_o,
    output logic [pipe_trk_pkg::XLEN-1:0] wb_pc_o,
    output logic                          wb_bubble_o
);

    logic [pipe_trk_pkg::N_STAGES-1:0][pipe_trk_pkg::XLEN-1:0] inst_in, inst_q;
    logic [pipe_trk_pkg::N_STAGES-1:0][pipe_trk_pkg::XLEN-1:0] pc_in, pc_q;
    logic [pipe_trk_pkg::N_STAGES-1:0] bubble_in, bubble_q;
    logic [pipe_trk_pkg::N_STAGES-1:0] hold, flush;

    // Per-stage controls
    assign hold[pipe_trk_pkg::STG_IF]   = pd_stall_i;
    assign hold[pipe_trk_pkg::STG_PD]   = id_stall_i;
    assign hold[pipe_trk_pkg::STG_ID]   = ex_stall_i;
    assign hold[pipe_trk_pkg::STG_EX]   = ex_stall_i;
    assign hold[pipe_trk_pkg::STG_MEM]  = wb_stall_i;
    assign hold[pipe_trk_pkg::STG_WB]   = wb_stall_i;
    assign flush[pipe_trk_pkg::STG_IF]  = pd_flush_i;
    assign flush[pipe_trk_pkg::STG_PD]  = bu_flush_i;
    assign flush[pipe_trk_pkg::STG_ID]  = bu_flush_i;
    assign flush[pipe_trk_pkg::STG_EX]  = bu_flush_i;
    assign flush[pipe_trk_pkg::STG_MEM] = 1'b0;  // Back end is never flushed
    assign flush[pipe_trk_pkg::STG_WB]  = 1'b0;

    always_comb begin
        inst_in[pipe_trk_pkg::STG_IF]   = fetch_inst_i;
        pc_in[pipe_trk_pkg::STG_IF]     = fetch_pc_i;
        bubble_in[pipe_trk_pkg::STG_IF] = !fetch_valid_i;
        for (int s = 1; s < pipe_trk_pkg::N_STAGES; s++) begin
            inst_in[s]   = inst_q[s-1];
            pc_in[s]     = pc_q[s-1];
            bubble_in[s] = bubble_q[s-1];
        end
        // Dependency stall leaves a bubble behind in id
        bubble_in[pipe_trk_pkg::STG_ID] = bubble_q[pipe_trk_pkg::STG_PD] | id_stall_i;
    end

    for (genvar g = 0; g < pipe_trk_pkg::N_STAGES; g++) begin : g_stage
        pipe_stage_reg #(.PC_RESET(PC_RESET)) stage_inst (
            .clk(clk), .rst(rst),
            .hold_i(hold[g]), .flush_i(flush[g]), .bubble_in_i(bubble_in[g]),
            .inst_i(inst_in[g]), .pc_i(pc_in[g]),
            .inst_o(inst_q[g]), .pc_o(pc_q[g]), .bubble_o(bubble_q[g])
        );
    end

    assign wb_inst_o   = inst_q[pipe_trk_pkg::STG_WB];
    assign wb_pc_o     = pc_q[pipe_trk_pkg::STG_WB];
    assign wb_bubble_o = bubble_q[pipe_trk_pkg::STG_WB];

endmodule

/* design/xori_result_check.sv */
`timescale 1ns/1ps

module xori_result_check (
    input  logic                          valid_i,
    input  logic                          is_xori_i,
    input  logic [pipe_trk_pkg::XLEN-1:0] rs1_value_i,
    input  logic [pipe_trk_pkg::XLEN-1:0] imm_i,      // Already sign-extended
    input  logic [pipe_trk_pkg::XLEN-1:0] result_i,
    output logic                          mismatch_o
);

    logic [pipe_trk_pkg::XLEN-1:0] expected;

    assign expected = rs1_value_i ^ imm_i;

    // Bubbles and other opcodes never flag
    assign mismatch_o = valid_i && is_xori_i && (result_i != expected);

endmodule

/* design/pipe_tracker_top.sv */
`timescale 1ns/1ps

module pipe_tracker_top #(
    parameter logic [pipe_trk_pkg::XLEN-1:0] PC_RESET = '0
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [pipe_trk_pkg::XLEN-1:0] fetch_inst_i,
    input  logic [pipe_trk_pkg::XLEN-1:0] fetch_pc_i,
    input  logic                          fetch_valid_i,
    input  logic                          pd_flush_i,
    input  logic                          bu_flush_i,
    input  logic                          pd_stall_i,
    input  logic                          id_stall_i,
    input  logic                          ex_stall_i,
    input  logic                          wb_stall_i,
    input  logic [pipe_trk_pkg::XLEN-1:0] wb_rs1_value_i,
    input  logic [pipe_trk_pkg::XLEN-1:0] wb_result_i,
    output logic                          fetch_illegal_o,
    output logic [pipe_trk_pkg::XLEN-1:0] wb_inst_o,
    output logic [pipe_trk_pkg::XLEN-1:0] wb_pc_o,
    output logic                          wb_valid_o,
    output logic                          xori_mismatch_o
);

    logic                          wb_bubble;
    logic                          wb_is_xori;
    logic [pipe_trk_pkg::XLEN-1:0] wb_imm_i;

    // Fetch side, legality only
    rv32i_decoder fetch_dec_inst (
        .inst_i(fetch_inst_i), .illegal_o(fetch_illegal_o),
        .is_xori_o(), .rs1_o(), .imm_i_o()
    );

    pipe_follower #(.PC_RESET(PC_RESET)) follower_inst (
        .clk(clk), .rst(rst),
        .fetch_inst_i(fetch_inst_i), .fetch_pc_i(fetch_pc_i), .fetch_valid_i(fetch_valid_i),
        .pd_flush_i(pd_flush_i), .bu_flush_i(bu_flush_i),
        .pd_stall_i(pd_stall_i), .id_stall_i(id_stall_i),
        .ex_stall_i(ex_stall_i), .wb_stall_i(wb_stall_i),
        .wb_inst_o(wb_inst_o), .wb_pc_o(wb_pc_o), .wb_bubble_o(wb_bubble)
    );

    assign wb_valid_o = !wb_bubble;

    // Write-back side, XORI recognition
    rv32i_decoder wb_dec_inst (
        .inst_i(wb_inst_o), .illegal_o(),
        .is_xori_o(wb_is_xori), .rs1_o(), .imm_i_o(wb_imm_i)
    );

    xori_result_check xori_chk_inst (
        .valid_i(wb_valid_o), .is_xori_i(wb_is_xori),
        .rs1_value_i(wb_rs1_value_i), .imm_i(wb_imm_i), .result_i(wb_result_i),
        .mismatch_o(xori_mismatch_o)
    );

endmodule

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS  = 8.0,
    parameter int  RST_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);  // Release away from the sampling edge
        rst_o = 1'b0;
    end

endmodule

/* verif/pipe_tracker_props.sv */
`timescale 1ns/1ps

module pipe_tracker_props (
    input logic        clk,
    input logic        rst,
    input logic        wb_stall_i,
    input logic [31:0] wb_inst_i,
    input logic [31:0] wb_pc_i,
    input logic        wb_valid_i
);

    // Write-back stage frozen while stalled
    wb_hold_a: assert property (@(posedge clk) disable iff (rst)
        wb_stall_i |=> ($stable(wb_inst_i) && $stable(wb_pc_i)))
        else $error("wb outputs changed while wb_stall_i was high");

    // Bubble flag held along with the word
    valid_hold_a: assert property (@(posedge clk) disable iff (rst)
        wb_stall_i |=> $stable(wb_valid_i))
        else $error("wb_valid_o changed while wb_stall_i was high");

    // Nothing in flight right out of reset
    reset_empty_a: assert property (@(posedge clk) $fell(rst) |-> !wb_valid_i)
        else $error("wb_valid_o high in the first cycle after reset");

endmodule

bind pipe_tracker_top pipe_tracker_props props_inst (
    .clk(clk), .rst(rst), .wb_stall_i(wb_stall_i),
    .wb_inst_i(wb_inst_o), .wb_pc_i(wb_pc_o), .wb_valid_i(wb_valid_o)
);

/* verif/pipe_tracker_tb.sv */
`timescale 1ns/1ps

module pipe_tracker_tb;

    localparam logic [31:0] PC_RESET    = 32'h0000_1000;
    localparam int          TEST_CYCLES = 12 + 110 + 800 + 320 + 200;
    localparam int          TIMEOUT_CYC = 2 * TEST_CYCLES;
    localparam int          WB          = pipe_trk_pkg::STG_WB;
    localparam int          MEM         = pipe_trk_pkg::STG_MEM;

    // Legal and illegal words of each opcode class
    localparam logic [31:0] DIRECTED [20] = '{
        32'h0000_00B7, 32'h0000_0097, 32'h0080_006F, 32'h0020_006F,
        32'h0000_8067, 32'h0000_1067, 32'h0020_8463, 32'h0000_2063,
        32'h0000_2003, 32'h0000_3003, 32'h0000_2023, 32'h0000_4023,
        32'h0000_4013, 32'h4000_1013, 32'h4000_0033, 32'h4000_1033,
        32'h0000_000F, 32'h0010_0073, 32'h0020_0073, 32'h0000_007F
    };

    logic        clk;
    logic        rst;
    logic [31:0] fetch_inst;
    logic [31:0] fetch_pc;
    logic [31:0] wb_rs1_value;
    logic [31:0] wb_result;
    logic [31:0] wb_inst;
    logic [31:0] wb_pc;
    logic        fetch_valid;
    logic        pd_flush;
    logic        bu_flush;
    logic        pd_stall;
    logic        id_stall;
    logic        ex_stall;
    logic        wb_stall;
    logic        fetch_illegal;
    logic        wb_valid;
    logic        xori_mismatch;

    logic [31:0] m_inst [pipe_trk_pkg::N_STAGES];  // Software copy of the stages
    logic [31:0] m_pc [pipe_trk_pkg::N_STAGES];
    logic        m_bub [pipe_trk_pkg::N_STAGES];
    logic [31:0] seed = 32'd14894;
    logic [31:0] exp_inst_q [$];
    logic [31:0] exp_pc_q [$];
    int          exp_cyc_q [$];
    logic [31:0] q_inst;
    logic [31:0] q_pc;
    int          q_cyc;
    int          cyc = 0;
    int          err_count = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          errs_before;
    logic [31:0] r;
    logic [31:0] w;
    bit          stream_on = 1'b0;

    tb_clk_gen #(.PERIOD_NS(8.0), .RST_CYCLES(8)) clk_gen_inst (.clk_o(clk), .rst_o(rst));

    pipe_tracker_top #(.PC_RESET(PC_RESET)) pipe_tracker_top_inst (
        .clk(clk), .rst(rst),
        .fetch_inst_i(fetch_inst), .fetch_pc_i(fetch_pc), .fetch_valid_i(fetch_valid),
        .pd_flush_i(pd_flush), .bu_flush_i(bu_flush), .pd_stall_i(pd_stall),
        .id_stall_i(id_stall), .ex_stall_i(ex_stall), .wb_stall_i(wb_stall),
        .wb_rs1_value_i(wb_rs1_value), .wb_result_i(wb_result),
        .fetch_illegal_o(fetch_illegal), .wb_inst_o(wb_inst), .wb_pc_o(wb_pc),
        .wb_valid_o(wb_valid), .xori_mismatch_o(xori_mismatch)
    );

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic expect_illegal(input logic [31:0] word);
        logic [2:0] f3;
        logic [6:0] f7;
        logic       ok;
        f3 = word[14:12];
        f7 = word[31:25];
        case (word[6:0])
            7'h37, 7'h17: ok = 1'b1;
            7'h6F: ok = !word[21];  // Target bit 1
            7'h67: ok = (f3 == 3'd0) && (word[21:20] == 2'b00);
            7'h63: ok = (f3 != 3'd2) && (f3 != 3'd3) && !word[8];
            7'h03: ok = (f3 != 3'd3) && (f3 < 3'd6);
            7'h23: ok = (f3 < 3'd3);
            7'h13: begin
                if (f3 == 3'd1)
                    ok = (f7 == 7'h00);
                else if (f3 == 3'd5)
                    ok = (f7 == 7'h00) || (f7 == 7'h20);
                else
                    ok = 1'b1;
            end
            7'h33: ok = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
            7'h0F: ok = (f3 == 3'd0);
            7'h73: ok = (word[31:21] == 11'd0) && (word[19:7] == 13'd0);
            default: ok = 1'b0;
        endcase
        return !ok;
    endfunction

    function automatic logic [31:0] xori_value(input logic [31:0] word, input logic [31:0] rs1);
        return rs1 ^ {{20{word[31]}}, word[31:20]};
    endfunction

    function automatic logic expect_mismatch(input logic [31:0] word, input logic valid);
        return valid && (word[6:0] == 7'h13) && (word[14:12] == 3'd4) &&
               (wb_result != xori_value(word, wb_rs1_value));
    endfunction

    // One clock edge of the stage rule
    // Steps wb first so each predecessor still holds its old value
    function automatic void step_model();
        logic hold;
        logic flush;
        for (int s = pipe_trk_pkg::N_STAGES - 1; s >= 0; s--) begin
            case (s)
                0: begin
                    hold  = pd_stall;
                    flush = pd_flush;
                end
                1: begin
                    hold  = id_stall;
                    flush = bu_flush;
                end
                2, 3: begin
                    hold  = ex_stall;
                    flush = bu_flush;
                end
                default: begin
                    hold  = wb_stall;
                    flush = 1'b0;
                end
            endcase
            if (rst) begin
                m_inst[s] = rv32i_isa_pkg::NOP_WORD;
                m_pc[s]   = PC_RESET;
                m_bub[s]  = 1'b1;
            end else if (flush) begin
                m_bub[s] = 1'b1;
            end else if (!hold && s == 0) begin
                m_inst[s] = fetch_inst;
                m_pc[s]   = fetch_pc;
                m_bub[s]  = !fetch_valid;
            end else if (!hold) begin
                m_inst[s] = m_inst[s-1];
                m_pc[s]   = m_pc[s-1];
                m_bub[s]  = m_bub[s-1] | ((s == pipe_trk_pkg::STG_ID) && id_stall);
            end
        end
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            $display("ERROR %s expected %h actual %h", name, exp_v, act_v);
            err_count++;
        end
    endtask

    task automatic finish_test(input string name);
        if (err_count == errs_before) begin
            tests_passed++;
            $display("Test %s passed", name);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", name, err_count - errs_before);
        end
        errs_before = err_count;
    endtask

    task automatic idle_controls();
        pd_flush = 1'b0;
        bu_flush = 1'b0;
        pd_stall = 1'b0;
        id_stall = 1'b0;
        ex_stall = 1'b0;
        wb_stall = 1'b0;
    endtask

    // Model steps at the edge and outputs are compared once settled
    always @(posedge clk) begin
        cyc++;
        if (stream_on && fetch_valid && !rst) begin
            exp_inst_q.push_back(fetch_inst);
            exp_pc_q.push_back(fetch_pc);
            exp_cyc_q.push_back(cyc);
        end
        step_model();
        #1;
        check_val("wb_inst_o", m_inst[WB], wb_inst);
        check_val("wb_pc_o", m_pc[WB], wb_pc);
        check_val("wb_valid_o", {31'd0, !m_bub[WB]}, {31'd0, wb_valid});
        check_val("fetch_illegal_o", {31'd0, expect_illegal(fetch_inst)}, {31'd0, fetch_illegal});
        check_val("xori_mismatch_o", {31'd0, expect_mismatch(m_inst[WB], !m_bub[WB])},
                  {31'd0, xori_mismatch});
        if (stream_on && wb_valid) begin
            assert (exp_inst_q.size() != 0) else begin
                $display("Instruction reached write-back that was never fetched");
                err_count++;
            end
            if (exp_inst_q.size() != 0) begin
                q_inst = exp_inst_q.pop_front();
                q_pc   = exp_pc_q.pop_front();
                q_cyc  = exp_cyc_q.pop_front();
                check_val("wb_inst_o", q_inst, wb_inst);
                check_val("wb_pc_o", q_pc, wb_pc);
                assert (cyc - q_cyc == 5) else begin
                    $display("Instruction took %0d cycles to reach write-back", cyc - q_cyc + 1);
                    err_count++;
                end
            end
        end
    end

    initial begin
        while (cyc < TIMEOUT_CYC) @(posedge clk);
        $display("Timeout after %0d cycles, tests did not complete", TIMEOUT_CYC);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        fetch_inst   = rv32i_isa_pkg::NOP_WORD;
        fetch_pc     = 32'd0;
        fetch_valid  = 1'b0;
        wb_rs1_value = 32'd0;
        wb_result    = 32'd0;
        idle_controls();
        errs_before = 0;

        // Reset state
        @(negedge clk);
        while (rst) @(negedge clk);
        repeat (2) @(negedge clk);
        check_val("wb_valid_o", 32'd0, {31'd0, wb_valid});
        check_val("wb_inst_o", rv32i_isa_pkg::NOP_WORD, wb_inst);
        check_val("wb_pc_o", PC_RESET, wb_pc);
        check_val("xori_mismatch_o", 32'd0, {31'd0, xori_mismatch});
        finish_test("reset");

        // Streaming with no stalls or flushes
        stream_on = 1'b1;
        for (int i = 0; i < 100; i++) begin
            fetch_inst  = lcg_next();
            fetch_pc    = PC_RESET + 32'(4 * i);
            fetch_valid = 1'b1;
            @(negedge clk);
        end
        fetch_valid = 1'b0;
        while (exp_inst_q.size() != 0) @(negedge clk);
        stream_on = 1'b0;
        finish_test("streaming");

        // Random stalls and flushes
        for (int i = 0; i < 800; i++) begin
            r = lcg_next();
            fetch_inst   = lcg_next();
            fetch_pc     = lcg_next();
            fetch_valid  = (r[31:30] != 2'b00);
            pd_stall     = (r[29:27] == 3'd0);
            id_stall     = (r[26:24] == 3'd0);
            ex_stall     = (r[23:21] == 3'd0);
            wb_stall     = (r[20:18] == 3'd0);
            pd_flush     = (r[17:14] == 4'd0);
            bu_flush     = (r[13:10] == 4'd0);
            wb_rs1_value = lcg_next();
            wb_result    = lcg_next();
            @(negedge clk);
        end
        idle_controls();
        finish_test("stalls_flushes");

        // Directed legality words then random ones
        for (int i = 0; i < 320; i++) begin
            fetch_inst  = (i < 20) ? DIRECTED[i] : lcg_next();
            fetch_valid = 1'b1;
            @(negedge clk);
        end
        finish_test("legality");

        // XORI results with an occasional flipped bit
        for (int i = 0; i < 200; i++) begin
            r = lcg_next();
            w = lcg_next();
            fetch_inst   = {w[31:15], (r[31:30] != 2'b00) ? rv32i_isa_pkg::F3_XOR : 3'b000,
                            w[11:7], rv32i_isa_pkg::OPC_I};
            fetch_valid  = r[29] | r[28];
            wb_rs1_value = lcg_next();
            wb_result    = xori_value(m_inst[MEM], wb_rs1_value) ^
                           (r[27] ? (32'd1 << r[20:16]) : 32'd0);  // Next wb word is in mem
            @(negedge clk);
        end
        fetch_valid = 1'b0;
        repeat (8) @(negedge clk);
        finish_test("xori_check");

        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && err_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* src.f */
design/rv32i_isa_pkg.sv
design/pipe_trk_pkg.sv
design/rv32i_decoder.sv
design/pipe_stage_reg.sv
design/pipe_follower.sv
design/xori_result_check.sv
design/pipe_tracker_top.sv
verif/tb_clk_gen.sv
verif/pipe_tracker_props.sv
verif/pipe_tracker_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= pipe_tracker_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
